// ==== logic/soc_defines.svh ====
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// Bus data width and word address width
`define ARCHBITSZ 32
`define ADDRBITSZ 14

// Address split, top bits pick a 4 KB slot and the rest is the word offset
`define SLOT_BITSZ 4
`define OFFSET_BITSZ 10

// Slaves that own a slot, the invalid slot has no enable
`define SLVCOUNT 3

// Peripheral sizes
`define GPIOCOUNT 8
`define INTSRCCOUNT 2

// System reset counter runs down from all ones
`define RST_CNTR_BITSZ 4

// Device table contents
`define SOCID 3
`define DEVID_DEVTBL 7
`define DEVID_GPIO 6
`define DEVID_INTCTRL 3
`define DEVCOUNT 3

`endif

// ==== logic/soc_pkg.sv ====
package soc_pkg;

	// PI1_RDWR returns the old value and writes the new one
	typedef enum logic [1:0] {
		PI1_NONE = 2'd0,
		PI1_WR   = 2'd1,
		PI1_RD   = 2'd2,
		PI1_RDWR = 2'd3
	} pi1_op_t;

	// Slot index, slots 3 to 15 all map to SLV_INVALID
	typedef enum logic [1:0] {
		SLV_DEVTBL  = 2'd0,
		SLV_GPIO    = 2'd1,
		SLV_INTCTRL = 2'd2,
		SLV_INVALID = 2'd3
	} slave_t;

	typedef enum logic [1:0] {
		RST_NONE   = 2'd0,
		RST_WARM   = 2'd1,
		RST_COLD   = 2'd2,
		RST_PWROFF = 2'd3
	} rst_req_t;

	typedef enum logic {
		INTC_IDLE = 1'b0,
		INTC_WAIT = 1'b1
	} intc_state_t;

endpackage

// ==== logic/pi1_router.sv ====
`timescale 1ns/100ps
`include "soc_defines.svh"

module pi1_router (
	input  logic                         clk_2x_w,
	input  logic                         rst_i,
	input  soc_pkg::pi1_op_t             pi1_op_i,
	input  logic [`ADDRBITSZ-1:0]        pi1_addr_i,
	input  logic [`ARCHBITSZ-1:0]        pi1_data_i,
	input  logic [`ARCHBITSZ/8-1:0]      pi1_sel_i,
	output logic [`ARCHBITSZ-1:0]        pi1_data_o,
	output logic                         pi1_rdy_o,
	output logic [1:0]                   slv_op_o,
	output logic [`OFFSET_BITSZ-1:0]     slv_offset_o,
	output logic [`ARCHBITSZ-1:0]        slv_data_o,
	output logic [`ARCHBITSZ/8-1:0]      slv_sel_o,
	output logic [`SLVCOUNT-1:0]         slv_en_o,
	input  logic [`ARCHBITSZ-1:0]        devtbl_data_i,
	input  logic [`ARCHBITSZ-1:0]        gpio_data_i,
	input  logic [`ARCHBITSZ-1:0]        intctrl_data_i
);
	import soc_pkg::*;

	logic [`SLOT_BITSZ-1:0] slot_bits;
	slave_t                 slot_dec;
	pi1_op_t                s1_op_q;
	slave_t                 s1_slot_q;
	logic [`ARCHBITSZ-1:0]  s2_data_q;
	logic                   s2_rdy_q;

	assign slot_bits = pi1_addr_i[`ADDRBITSZ-1 -: `SLOT_BITSZ];

	always_comb begin
		case (slot_bits)
			0:       slot_dec = SLV_DEVTBL;
			1:       slot_dec = SLV_GPIO;
			2:       slot_dec = SLV_INTCTRL;
			default: slot_dec = SLV_INVALID;
		endcase
	end

	// Stage 1, request register seen by every slave
	always_ff @(posedge clk_2x_w) begin
		if (rst_i) begin
			s1_op_q <= PI1_NONE;
		end else begin
			s1_op_q <= pi1_op_i;
		end
		s1_slot_q    <= slot_dec;
		slv_offset_o <= pi1_addr_i[`OFFSET_BITSZ-1:0];
		slv_data_o   <= pi1_data_i;
		slv_sel_o    <= pi1_sel_i;
	end

	assign slv_op_o = s1_op_q;
	assign slv_en_o = (s1_op_q != PI1_NONE && s1_slot_q != SLV_INVALID) ?
		(`SLVCOUNT'(1) << s1_slot_q) : '0;

	// Stage 2 captures the old value, slaves update on this same edge
	always_ff @(posedge clk_2x_w) begin
		if (rst_i) begin
			s2_rdy_q <= 1'b0;
		end else begin
			s2_rdy_q <= (s1_op_q != PI1_NONE);
		end
		case (s1_slot_q)
			SLV_DEVTBL:  s2_data_q <= devtbl_data_i;
			SLV_GPIO:    s2_data_q <= gpio_data_i;
			SLV_INTCTRL: s2_data_q <= intctrl_data_i;
			default:     s2_data_q <= '0;
		endcase
	end

	assign pi1_data_o = s2_data_q;
	assign pi1_rdy_o  = s2_rdy_q;

	// Two ready cycles in a row need two requests in a row
	a_rdy_back_to_back: assert property (@(posedge clk_2x_w) disable iff (rst_i)
		pi1_rdy_o && $past(pi1_rdy_o) |->
			$past(pi1_op_i, 2) != PI1_NONE && $past(pi1_op_i, 3) != PI1_NONE);

endmodule

// ==== logic/devtbl.sv ====
`timescale 1ns/100ps
`include "soc_defines.svh"

module devtbl (
	input  logic                     clk_2x_w,
	input  logic                     rst_i,
	input  logic                     en_i,
	input  logic [1:0]               op_i,
	input  logic [`OFFSET_BITSZ-1:0] offset_i,
	input  logic [`ARCHBITSZ-1:0]    data_i,
	input  logic [`ARCHBITSZ/8-1:0]  sel_i,
	output logic [`ARCHBITSZ-1:0]    data_o,
	output logic                     rst0_o,
	output logic                     rst1_o
);
	import soc_pkg::*;

	logic wr_rst;

	// Bit 31 flags interrupt use, the low byte is the device id
	function automatic logic [`ARCHBITSZ-1:0] entry(input logic useintr, input logic [7:0] id);
		logic [`ARCHBITSZ-1:0] e;
		e = '0;
		e[`ARCHBITSZ-1] = useintr;
		e[7:0] = id;
		return e;
	endfunction

	always_comb begin
		data_o = '0;
		case (offset_i)
			0: data_o[7:0] = 8'(`SOCID);
			1: data_o[7:0] = 8'(`DEVCOUNT);
			2: data_o = entry(1'b0, 8'(`DEVID_DEVTBL));
			3: data_o = entry(1'b1, 8'(`DEVID_GPIO));
			4: data_o = entry(1'b0, 8'(`DEVID_INTCTRL));
			default: data_o = '0;
		endcase
	end

	// Software reset request lives in byte 0 of offset 0
	assign wr_rst = en_i && (op_i == PI1_WR || op_i == PI1_RDWR) &&
		offset_i == '0 && sel_i[0];

	always_ff @(posedge clk_2x_w) begin
		if (rst_i) begin
			rst0_o <= 1'b0;
			rst1_o <= 1'b0;
		end else if (wr_rst) begin
			rst0_o <= data_i[0];
			rst1_o <= data_i[1];
		end
	end

endmodule

// ==== logic/gpio_port.sv ====
`timescale 1ns/100ps
`include "soc_defines.svh"

module gpio_port (
	input  logic                     clk_2x_w,
	input  logic                     rst_i,
	input  logic                     en_i,
	input  logic [1:0]               op_i,
	input  logic [`OFFSET_BITSZ-1:0] offset_i,
	input  logic [`ARCHBITSZ-1:0]    data_i,
	input  logic [`ARCHBITSZ/8-1:0]  sel_i,
	output logic [`ARCHBITSZ-1:0]    data_o,
	input  logic [`GPIOCOUNT-1:0]    gp_i,
	output logic [`GPIOCOUNT-1:0]    gp_o,
	output logic                     intrqst_o,
	input  logic                     intrdy_i
);
	import soc_pkg::*;

	logic [`GPIOCOUNT-1:0] sync1_q;
	logic [`GPIOCOUNT-1:0] sync2_q;
	logic [`GPIOCOUNT-1:0] prev_q;
	logic [`GPIOCOUNT-1:0] out_q;
	logic [`GPIOCOUNT-1:0] mask_q;
	logic [`GPIOCOUNT-1:0] chg;
	logic                  wr;
	logic                  pend_q;

	// Two-flop synchronizer plus the previous sample for edge detect
	always_ff @(posedge clk_2x_w) begin
		sync1_q <= gp_i;
		sync2_q <= sync1_q;
		prev_q  <= sync2_q;
	end

	assign chg = (sync2_q ^ prev_q) & mask_q;
	assign wr  = en_i && (op_i == PI1_WR || op_i == PI1_RDWR);

	always_ff @(posedge clk_2x_w) begin
		if (rst_i) begin
			out_q  <= '0;
			mask_q <= '0;
			pend_q <= 1'b0;
		end else begin
			for (int b = 0; b < `GPIOCOUNT/8; b++) begin
				if (wr && sel_i[b] && offset_i == 1) out_q[b*8 +: 8] <= data_i[b*8 +: 8];
				if (wr && sel_i[b] && offset_i == 2) mask_q[b*8 +: 8] <= data_i[b*8 +: 8];
			end
			// A fresh change re-arms even in the ack cycle
			pend_q <= (|chg) || (pend_q && !intrdy_i);
		end
	end

	always_comb begin
		data_o = '0;
		case (offset_i)
			0: data_o[`GPIOCOUNT-1:0] = sync2_q;
			1: data_o[`GPIOCOUNT-1:0] = out_q;
			2: data_o[`GPIOCOUNT-1:0] = mask_q;
			default: data_o = '0;
		endcase
	end

	assign gp_o      = out_q;
	assign intrqst_o = pend_q;

endmodule

// ==== logic/intctrl.sv ====
`timescale 1ns/100ps
`include "soc_defines.svh"

module intctrl (
	input  logic                     clk_2x_w,
	input  logic                     rst_i,
	input  logic                     en_i,
	input  logic [1:0]               op_i,
	input  logic [`OFFSET_BITSZ-1:0] offset_i,
	output logic [`ARCHBITSZ-1:0]    data_o,
	input  logic [`INTSRCCOUNT-1:0]  intrqstsrc_i,
	output logic [`INTSRCCOUNT-1:0]  intrdysrc_o,
	output logic                     intrqst_o,
	input  logic                     intrdy_i
);
	import soc_pkg::*;

	localparam int IDXW = $clog2(`INTSRCCOUNT);

	intc_state_t             state_q;
	logic [IDXW-1:0]         cur_q;
	logic [IDXW:0]           last_q;
	logic [IDXW-1:0]         pick;
	logic [`INTSRCCOUNT-1:0] pend;
	logic                    rd_hit;

	// The source being acked still holds its level this cycle
	assign pend = intrqstsrc_i & ~intrdysrc_o;

	// Lowest index wins
	always_comb begin
		pick = '0;
		for (int i = `INTSRCCOUNT-1; i >= 0; i--) begin
			if (pend[i]) pick = IDXW'(i);
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (rst_i) begin
			state_q     <= INTC_IDLE;
			last_q      <= '0;
			intrdysrc_o <= '0;
		end else begin
			intrdysrc_o <= '0;
			case (state_q)
				INTC_IDLE: begin
					if (|pend) begin
						cur_q   <= pick;
						state_q <= INTC_WAIT;
					end
				end
				INTC_WAIT: begin
					if (intrdy_i) begin
						intrdysrc_o <= `INTSRCCOUNT'(1) << cur_q;
						last_q      <= {1'b0, cur_q} + 1'b1;
						state_q     <= INTC_IDLE;
					end
				end
				default: state_q <= INTC_IDLE;
			endcase
		end
	end

	assign intrqst_o = (state_q == INTC_WAIT);

	// Offset 0 gives last serviced index plus one or zero before any service
	assign rd_hit = en_i && (op_i == PI1_RD || op_i == PI1_RDWR) && offset_i == '0;

	always_comb begin
		data_o = '0;
		if (rd_hit) data_o[IDXW:0] = last_q;
	end

	a_ack_onehot: assert property (@(posedge clk_2x_w) disable iff (rst_i)
		$onehot0(intrdysrc_o));

endmodule

// ==== logic/rst_ctrl.sv ====
`timescale 1ns/100ps
`include "soc_defines.svh"

module rst_ctrl (
	input  logic clk_2x_w,
	input  logic rst_p,
	input  logic rst0_i,
	input  logic rst1_i,
	output logic soc_rst_o,
	output logic pwroff_o
);
	import soc_pkg::*;

	rst_req_t                   req;
	logic [`RST_CNTR_BITSZ-1:0] cnt_q;
	logic                       pwroff_q;

	always_comb begin
		case ({rst1_i, rst0_i})
			2'b11:   req = RST_COLD;
			2'b10:   req = RST_WARM;
			2'b01:   req = RST_PWROFF;
			default: req = RST_NONE;
		endcase
	end

	// Cold and warm both just restart the counter here
	always_ff @(posedge clk_2x_w) begin
		if (rst_p || req == RST_WARM || req == RST_COLD) begin
			cnt_q <= '1;
		end else if (cnt_q != '0) begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	// Power-off sticks until the board reset
	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (req == RST_PWROFF) begin
			pwroff_q <= 1'b1;
		end
	end

	assign soc_rst_o = rst_p || pwroff_q || (cnt_q != '0);
	assign pwroff_o  = pwroff_q;

endmodule

// ==== logic/soc_top.sv ====
`timescale 1ns/100ps
`include "soc_defines.svh"

module soc_top (
	input  logic                    clk_2x_w,
	input  logic                    rst_p,
	input  soc_pkg::pi1_op_t        pi1_op_i,
	input  logic [`ADDRBITSZ-1:0]   pi1_addr_i,
	input  logic [`ARCHBITSZ-1:0]   pi1_data_i,
	input  logic [`ARCHBITSZ/8-1:0] pi1_sel_i,
	output logic [`ARCHBITSZ-1:0]   pi1_data_o,
	output logic                    pi1_rdy_o,
	input  logic [`GPIOCOUNT-1:0]   gp_i,
	output logic [`GPIOCOUNT-1:0]   gp_o,
	input  logic                    ext_intr_i,
	output logic                    intrqst_o,
	input  logic                    intrdy_i,
	output logic                    soc_rst_o,
	output logic                    pwroff_o
);

	logic                     soc_rst_w;
	logic [1:0]               slv_op_w;
	logic [`OFFSET_BITSZ-1:0] slv_offset_w;
	logic [`ARCHBITSZ-1:0]    slv_data_w;
	logic [`ARCHBITSZ/8-1:0]  slv_sel_w;
	logic [`SLVCOUNT-1:0]     slv_en_w;
	logic [`ARCHBITSZ-1:0]    devtbl_data_w;
	logic [`ARCHBITSZ-1:0]    gpio_data_w;
	logic [`ARCHBITSZ-1:0]    intctrl_data_w;
	logic                     devtbl_rst0_w;
	logic                     devtbl_rst1_w;
	logic                     gpio_intrqst_w;
	logic [`INTSRCCOUNT-1:0]  intrdysrc_w;

	pi1_router pi1_router_inst (
		.clk_2x_w(clk_2x_w), .rst_i(soc_rst_w),
		.pi1_op_i(pi1_op_i), .pi1_addr_i(pi1_addr_i), .pi1_data_i(pi1_data_i),
		.pi1_sel_i(pi1_sel_i), .pi1_data_o(pi1_data_o), .pi1_rdy_o(pi1_rdy_o),
		.slv_op_o(slv_op_w), .slv_offset_o(slv_offset_w), .slv_data_o(slv_data_w),
		.slv_sel_o(slv_sel_w), .slv_en_o(slv_en_w),
		.devtbl_data_i(devtbl_data_w), .gpio_data_i(gpio_data_w),
		.intctrl_data_i(intctrl_data_w)
	);

	// Slot order matches slave_t
	devtbl devtbl_inst (
		.clk_2x_w(clk_2x_w), .rst_i(soc_rst_w), .en_i(slv_en_w[0]),
		.op_i(slv_op_w), .offset_i(slv_offset_w), .data_i(slv_data_w), .sel_i(slv_sel_w),
		.data_o(devtbl_data_w), .rst0_o(devtbl_rst0_w), .rst1_o(devtbl_rst1_w)
	);

	gpio_port gpio_port_inst (
		.clk_2x_w(clk_2x_w), .rst_i(soc_rst_w), .en_i(slv_en_w[1]),
		.op_i(slv_op_w), .offset_i(slv_offset_w), .data_i(slv_data_w), .sel_i(slv_sel_w),
		.data_o(gpio_data_w), .gp_i(gp_i), .gp_o(gp_o),
		.intrqst_o(gpio_intrqst_w), .intrdy_i(intrdysrc_w[0])
	);

	// Source 0 is gpio, source 1 is the external level
	intctrl intctrl_inst (
		.clk_2x_w(clk_2x_w), .rst_i(soc_rst_w), .en_i(slv_en_w[2]),
		.op_i(slv_op_w), .offset_i(slv_offset_w), .data_o(intctrl_data_w),
		.intrqstsrc_i({ext_intr_i, gpio_intrqst_w}), .intrdysrc_o(intrdysrc_w),
		.intrqst_o(intrqst_o), .intrdy_i(intrdy_i)
	);

	rst_ctrl rst_ctrl_inst (
		.clk_2x_w(clk_2x_w), .rst_p(rst_p), .rst0_i(devtbl_rst0_w), .rst1_i(devtbl_rst1_w),
		.soc_rst_o(soc_rst_w), .pwroff_o(pwroff_o)
	);

	assign soc_rst_o = soc_rst_w;

endmodule

// ==== dv/tb_clkgen.sv ====
`timescale 1ns/100ps

module tb_clkgen (
	input  logic hold_rst_i,
	output logic clk_2x_w,
	output logic rst_p
);
	logic por_q;

	// 20 ns period
	initial begin
		clk_2x_w = 1'b0;
		forever #10 clk_2x_w = ~clk_2x_w;
	end

	// Power-on reset for 8 cycles, released just after an edge
	initial begin
		por_q = 1'b1;
		repeat (8) @(posedge clk_2x_w);
		#2;
		por_q = 1'b0;
	end

	assign rst_p = por_q || hold_rst_i;

endmodule

// ==== dv/tb_soc_top.sv ====
`timescale 1ns/100ps
`include "soc_defines.svh"

module tb_soc_top;
	import soc_pkg::*;

	localparam int NUM_TXN         = 300;
	localparam int WATCHDOG_CYCLES = NUM_TXN * 10 + 2000;
	localparam int RST_CYCLES      = (1 << `RST_CNTR_BITSZ) - 1;

	logic                    clk_2x_w;
	logic                    rst_p;
	logic                    hold_rst;
	pi1_op_t                 pi1_op;
	logic [`ADDRBITSZ-1:0]   pi1_addr;
	logic [`ARCHBITSZ-1:0]   pi1_wdata;
	logic [`ARCHBITSZ/8-1:0] pi1_sel;
	logic [`ARCHBITSZ-1:0]   pi1_rdata;
	logic                    pi1_rdy;
	logic [`GPIOCOUNT-1:0]   gp_in;
	logic [`GPIOCOUNT-1:0]   gp_out;
	logic                    ext_intr;
	logic                    intrqst;
	logic                    intrdy;
	logic                    soc_rst;
	logic                    pwroff;

	// Reference model state and the responses still in flight
	logic [7:0]  model_out;
	logic [7:0]  model_mask;
	logic [31:0] model_last;
	logic [31:0] exp_data_q[$];
	logic [7:0]  exp_gp_q[$];
	bit          exp_chk_q[$];
	int          exp_due_q[$];
	int          cyc = 0;
	int          n_checks = 0;
	int          n_errors = 0;

	tb_clkgen tb_clkgen_inst (.hold_rst_i(hold_rst), .clk_2x_w(clk_2x_w), .rst_p(rst_p));

	soc_top soc_top_inst (
		.clk_2x_w(clk_2x_w), .rst_p(rst_p),
		.pi1_op_i(pi1_op), .pi1_addr_i(pi1_addr), .pi1_data_i(pi1_wdata),
		.pi1_sel_i(pi1_sel), .pi1_data_o(pi1_rdata), .pi1_rdy_o(pi1_rdy),
		.gp_i(gp_in), .gp_o(gp_out), .ext_intr_i(ext_intr),
		.intrqst_o(intrqst), .intrdy_i(intrdy),
		.soc_rst_o(soc_rst), .pwroff_o(pwroff)
	);

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("error at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic report_failure(input string msg);
		n_errors++;
		$display("failure at %0t: %s", $time, msg);
	endtask

	// Register map as software sees it
	function automatic logic [31:0] model_read(input int slot, input int offset);
		case (slot)
			0: begin
				case (offset)
					0: return `SOCID;
					1: return `DEVCOUNT;
					2: return `DEVID_DEVTBL;
					3: return 32'h8000_0000 | `DEVID_GPIO;
					4: return `DEVID_INTCTRL;
					default: return 0;
				endcase
			end
			1: begin
				case (offset)
					0: return gp_in;
					1: return model_out;
					2: return model_mask;
					default: return 0;
				endcase
			end
			2: return (offset == 0) ? model_last : 0;
			default: return 0;
		endcase
	endfunction

	task automatic bus_req(input pi1_op_t op, input int slot, input int offset,
			input logic [31:0] data, input logic [`ARCHBITSZ/8-1:0] sel);
		@(posedge clk_2x_w);
		#2;
		pi1_op    = op;
		pi1_addr  = {slot[3:0], offset[9:0]};
		pi1_wdata = data;
		pi1_sel   = sel;
		exp_data_q.push_back(model_read(slot, offset));
		exp_chk_q.push_back(op != PI1_WR);
		exp_due_q.push_back(cyc + 2);
		// Only byte 0 holds gpio bits
		if (op != PI1_RD && slot == 1 && sel[0]) begin
			if (offset == 1)
				model_out = data[7:0];
			if (offset == 2)
				model_mask = data[7:0];
		end
		exp_gp_q.push_back(model_out);
	endtask

	task automatic drive_idle();
		@(posedge clk_2x_w);
		#2;
		pi1_op = PI1_NONE;
		intrdy = 1'b0;
	endtask

	task automatic pop_expect();
		exp_data_q.delete(0);
		exp_gp_q.delete(0);
		exp_chk_q.delete(0);
		exp_due_q.delete(0);
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		while (exp_due_q.size() != 0 && n < 20) begin
			drive_idle();
			n++;
		end
		if (exp_due_q.size() != 0)
			report_failure("bus responses still missing after 20 cycles");
	endtask

	// which 0 polls intrqst_o, which 1 polls soc_rst_o
	task automatic wait_for(input bit which, input logic level, input string what);
		int n;
		logic v;
		n = 0;
		v = ~level;
		while (v !== level && n < 40) begin
			drive_idle();
			v = which ? soc_rst : intrqst;
			n++;
		end
		if (v !== level)
			report_failure({"timed out waiting for ", what});
	endtask

	task automatic count_reset(output int n);
		n = 0;
		do begin
			@(posedge clk_2x_w);
			#1;
			n++;
		end while (soc_rst === 1'b1 && n < 40);
	endtask

	// Response monitor, sampled 1 ns after the edge
	initial begin
		forever begin
			@(posedge clk_2x_w);
			cyc++;
			#1;
			if (pi1_rdy === 1'b1) begin
				if (exp_due_q.size() == 0) begin
					report_failure("pi1_rdy_o raised with no request in flight");
				end else begin
					check_value("pi1_rdy_o cycle", exp_due_q[0], cyc);
					if (exp_chk_q[0])
						check_value("pi1_data_o", exp_data_q[0], pi1_rdata);
					check_value("gp_o", exp_gp_q[0], gp_out);
					pop_expect();
				end
			end else if (exp_due_q.size() != 0 && exp_due_q[0] <= cyc) begin
				report_failure("pi1_rdy_o missing two cycles after a request");
				pop_expect();
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_2x_w);
		$display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		int n;
		int t;
		int slot;
		int off;
		int pin_en;
		int pin_dis;
		logic [7:0] mask;
		n = $urandom(32'h2929_f9d2);
		hold_rst   = 1'b0;
		pi1_op     = PI1_NONE;
		pi1_addr   = '0;
		pi1_wdata  = '0;
		pi1_sel    = '0;
		gp_in      = $urandom;
		ext_intr   = 1'b0;
		intrdy     = 1'b0;
		model_out  = '0;
		model_mask = '0;
		model_last = '0;

		// Reset release
		@(negedge rst_p);
		count_reset(n);
		check_value("soc_rst_o cycles", RST_CYCLES, n);
		check_value("pi1_rdy_o", 0, pi1_rdy);
		check_value("intrqst_o", 0, intrqst);
		check_value("gp_o", 0, gp_out);
		check_value("pwroff_o", 0, pwroff);

		// Random traffic to gpio registers and invalid slots, with some bubbles
		for (int i = 0; i < NUM_TXN; i++) begin
			if ($urandom % 4 == 0) begin
				drive_idle();
			end else begin
				t    = $urandom % 4;
				slot = (t == 3) ? 3 + $urandom % 13 : 1;
				off  = (t == 3) ? $urandom % 1024 : t;
				bus_req(pi1_op_t'(1 + $urandom % 3), slot, off, $urandom, $urandom % 16);
			end
		end
		wait_done();

		// Device table, including one offset past the entries
		for (int k = 0; k < `DEVCOUNT + 3; k++) begin
			bus_req(PI1_RD, 0, k, 0, 0);
		end
		wait_done();

		// Interrupts, one enabled and one disabled pin
		pin_en  = $urandom % 8;
		pin_dis = (pin_en + 1 + $urandom % 7) % 8;
		mask    = ($urandom | (1 << pin_en)) & ~(1 << pin_dis);
		bus_req(PI1_WR, 1, 2, mask, 4'h1);
		wait_done();
		gp_in[pin_dis] = ~gp_in[pin_dis];
		repeat (10) begin
			drive_idle();
			check_value("intrqst_o", 0, intrqst);
		end
		// Sync takes 2 cycles and the gpio request 1 more, ext joins it there
		gp_in[pin_en] = ~gp_in[pin_en];
		repeat (3) drive_idle();
		ext_intr = 1'b1;
		wait_for(0, 1'b1, "intrqst_o");
		model_last = 1;
		intrdy = 1'b1;
		drive_idle();
		bus_req(PI1_RD, 2, 0, 0, 0);
		wait_done();
		wait_for(0, 1'b1, "intrqst_o");
		model_last = 2;
		intrdy = 1'b1;
		drive_idle();
		ext_intr = 1'b0;
		bus_req(PI1_RD, 2, 0, 0, 0);
		wait_done();
		check_value("intrqst_o", 0, intrqst);

		// Warm reset clears the gpio registers
		bus_req(PI1_WR, 1, 1, $urandom | 1, 4'hf);
		bus_req(PI1_WR, 1, 2, 8'hff, 4'h1);
		bus_req(PI1_WR, 0, 0, 2, 4'h1);
		wait_done();
		wait_for(1, 1'b1, "soc_rst_o high");
		wait_for(1, 1'b0, "soc_rst_o low");
		model_out  = '0;
		model_mask = '0;
		model_last = '0;
		check_value("gp_o", 0, gp_out);
		bus_req(PI1_RD, 1, 1, 0, 0);
		bus_req(PI1_RD, 1, 2, 0, 0);
		wait_done();

		// Power-off holds the system in reset until the board reset
		bus_req(PI1_WR, 0, 0, 1, 4'h1);
		wait_done();
		wait_for(1, 1'b1, "soc_rst_o high");
		repeat (20) begin
			drive_idle();
			check_value("soc_rst_o", 1, soc_rst);
		end
		check_value("pwroff_o", 1, pwroff);
		hold_rst = 1'b1;
		repeat (4) drive_idle();
		hold_rst = 1'b0;
		count_reset(n);
		check_value("soc_rst_o cycles", RST_CYCLES, n);
		check_value("pwroff_o", 0, pwroff);

		$display("summary: %0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+logic
logic/soc_pkg.sv
logic/pi1_router.sv
logic/devtbl.sv
logic/gpio_port.sv
logic/intctrl.sv
logic/rst_ctrl.sv
logic/soc_top.sv
dv/tb_clkgen.sv
dv/tb_soc_top.sv

// ==== Bender.yml ====
package:
  name: soc_periph

sources:
  - include_dirs:
      - logic
    files:
      - logic/soc_pkg.sv
      - logic/pi1_router.sv
      - logic/devtbl.sv
      - logic/gpio_port.sv
      - logic/intctrl.sv
      - logic/rst_ctrl.sv
      - logic/soc_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/tb_clkgen.sv
      - dv/tb_soc_top.sv
